//--- verilog/axi_mem_geom_pkg.sv
/*
 * Channel geometry package
 * Address, data and ID widths of the memory channel
 * Tracker and response queue depths
 */

package axi_mem_geom_pkg;

    // Word address into the 64-word native memory
    localparam int ADDR_WIDTH = 6;
    localparam int DATA_WIDTH = 16;

    // The accelerator issues wider IDs than the memory can return
    localparam int SRC_ID_WIDTH = 6;
    localparam int SINK_ID_WIDTH = 4;

    // Outstanding requests per direction held by the shim
    localparam int TRACK_ENTRIES = 8;
    // Responses buffered per direction inside the memory
    localparam int RESP_QUEUE_ENTRIES = 4;

    typedef logic [ADDR_WIDTH-1:0] t_addr;
    typedef logic [DATA_WIDTH-1:0] t_data;
    typedef logic [SRC_ID_WIDTH-1:0] t_src_id;
    typedef logic [SINK_ID_WIDTH-1:0] t_sink_id;

endpackage

//--- verilog/mem_user_pkg.sv
/*
 * User field layout package
 * Field is { accelerator user, device flags, PIM flags }
 */

package mem_user_pkg;

    // PIM flags sit in the low bits and are only carried back with responses
    localparam int PIM_FLAG_WIDTH = 2;
    // Device flags are the only user bits the native memory sees
    localparam int FIM_USER_WIDTH = 2;
    localparam int FIM_USER_START = PIM_FLAG_WIDTH;
    // Accelerator bits are opaque and returned unchanged
    localparam int AFU_USER_WIDTH = 8;
    localparam int USER_WIDTH = PIM_FLAG_WIDTH + FIM_USER_WIDTH + AFU_USER_WIDTH;

    // Device flag index that limits a write to data bits 7..0
    localparam int FIM_FLAG_LOW_BYTE = 0;

    typedef logic [USER_WIDTH-1:0] t_user;
    typedef logic [FIM_USER_WIDTH-1:0] t_fim_user;

endpackage

//--- verilog/axi_mem_if.sv
/*
 * Single-beat memory channel interface
 * Groups aw, w, b, ar and r with valid/ready handshakes
 * Modports to_sink and to_source
 */
`timescale 1ns/100ps

interface axi_mem_if
    import axi_mem_geom_pkg::*;
#(
    parameter int ID_WIDTH = 4,
    parameter int U_WIDTH = 2
)
(
    input logic clk,
    input logic rst_n
);

    // Write address group
    logic aw_valid;
    logic aw_ready;
    logic [ID_WIDTH-1:0] aw_id;
    t_addr aw_addr;
    logic [U_WIDTH-1:0] aw_user;

    // Write data group, one beat per write
    logic w_valid;
    logic w_ready;
    t_data w_data;

    // Write response group
    logic b_valid;
    logic b_ready;
    logic [ID_WIDTH-1:0] b_id;
    logic [U_WIDTH-1:0] b_user;

    // Read address group
    logic ar_valid;
    logic ar_ready;
    logic [ID_WIDTH-1:0] ar_id;
    t_addr ar_addr;
    logic [U_WIDTH-1:0] ar_user;

    // Read response group
    logic r_valid;
    logic r_ready;
    logic [ID_WIDTH-1:0] r_id;
    t_data r_data;
    logic [U_WIDTH-1:0] r_user;

    // Requester side, which issues requests and accepts responses
    modport to_sink (
        input clk, rst_n,
        output aw_valid, aw_id, aw_addr, aw_user, input aw_ready,
        output w_valid, w_data, input w_ready,
        input b_valid, b_id, b_user, output b_ready,
        output ar_valid, ar_id, ar_addr, ar_user, input ar_ready,
        input r_valid, r_id, r_data, r_user, output r_ready
    );

    // Responder side, which accepts requests and returns responses
    modport to_source (
        input clk, rst_n,
        input aw_valid, aw_id, aw_addr, aw_user, output aw_ready,
        input w_valid, w_data, output w_ready,
        output b_valid, b_id, b_user, input b_ready,
        input ar_valid, ar_id, ar_addr, ar_user, output ar_ready,
        output r_valid, r_id, r_data, r_user, input r_ready
    );

endinterface

//--- verilog/mem_track_fifo.sv
/*
 * Register-array FIFO with first-word fall-through
 * Circular buffer with read and write pointers and an entry count
 */
`timescale 1ns/100ps

module mem_track_fifo
#(
    parameter int N_DATA_BITS = 8,
    parameter int N_ENTRIES = 4
)
(
    input logic clk,
    input logic rst_n,

    input logic enq_en,
    input logic [N_DATA_BITS-1:0] enq_data,
    output logic not_full,

    input logic deq_en,
    output logic [N_DATA_BITS-1:0] first,
    output logic not_empty
);

    typedef logic [$clog2(N_ENTRIES)-1:0] t_ptr;
    typedef logic [$clog2(N_ENTRIES+1)-1:0] t_count;

    logic [N_DATA_BITS-1:0] entries [N_ENTRIES];
    t_ptr wr_ptr;
    t_ptr rd_ptr;
    t_count count;

    logic do_enq;
    logic do_deq;

    // A full FIFO still takes a new entry when the head leaves on the same edge
    assign do_deq = deq_en && (count != '0);
    assign do_enq = enq_en && ((count != t_count'(N_ENTRIES)) || do_deq);

    assign not_full = (count != t_count'(N_ENTRIES));
    assign not_empty = (count != '0);
    // The head entry is visible without a dequeue
    assign first = entries[rd_ptr];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_enq)
            begin
                wr_ptr <= (wr_ptr == t_ptr'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq)
            begin
                rd_ptr <= (rd_ptr == t_ptr'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Count is unchanged when both happen together
            if (do_enq && !do_deq)
            begin
                count <= count + 1'b1;
            end
            else if (do_deq && !do_enq)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage holds payload only
    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            entries[wr_ptr] <= enq_data;
        end
    end

endmodule

//--- verilog/axi_mem_user_ext.sv
/*
 * User field and ID extension shim
 * Tracks full request ID and user field in in-order FIFOs
 * Restores them on each response from the narrower sink
 */
`timescale 1ns/100ps

module axi_mem_user_ext
    import axi_mem_geom_pkg::*, mem_user_pkg::*;
(
    axi_mem_if.to_sink mem_sink,
    axi_mem_if.to_source mem_source
);

    logic clk;
    logic rst_n;

    assign clk = mem_sink.clk;
    assign rst_n = mem_sink.rst_n;

    logic wr_not_full;
    logic wr_not_empty;
    t_src_id wr_saved_id;
    t_user wr_saved_user;

    logic rd_not_full;
    logic rd_not_empty;
    t_src_id rd_saved_id;
    t_user rd_saved_user;

    // Write tracker holds one entry per write still waiting for its b response
    mem_track_fifo #(
        .N_DATA_BITS(SRC_ID_WIDTH + USER_WIDTH),
        .N_ENTRIES(TRACK_ENTRIES)
    ) wr_track (
        .clk,
        .rst_n,
        .enq_en(mem_source.aw_valid && mem_source.aw_ready),
        .enq_data({mem_source.aw_id, mem_source.aw_user}),
        .not_full(wr_not_full),
        .deq_en(mem_source.b_valid && mem_source.b_ready),
        .first({wr_saved_id, wr_saved_user}),
        .not_empty(wr_not_empty)
    );

    // Read tracker works the same way for ar and r
    mem_track_fifo #(
        .N_DATA_BITS(SRC_ID_WIDTH + USER_WIDTH),
        .N_ENTRIES(TRACK_ENTRIES)
    ) rd_track (
        .clk,
        .rst_n,
        .enq_en(mem_source.ar_valid && mem_source.ar_ready),
        .enq_data({mem_source.ar_id, mem_source.ar_user}),
        .not_full(rd_not_full),
        .deq_en(mem_source.r_valid && mem_source.r_ready),
        .first({rd_saved_id, rd_saved_user}),
        .not_empty(rd_not_empty)
    );

    always_comb
    begin
        // Requests are hidden from the sink while a tracker is full, so both
        // sides of the shim always accept on the same edge
        mem_sink.aw_valid = mem_source.aw_valid && wr_not_full;
        mem_source.aw_ready = mem_sink.aw_ready && wr_not_full;
        mem_sink.aw_id = mem_source.aw_id[SINK_ID_WIDTH-1:0];
        mem_sink.aw_addr = mem_source.aw_addr;
        // Only the device flags reach the memory
        mem_sink.aw_user = mem_source.aw_user[FIM_USER_START +: FIM_USER_WIDTH];

        mem_sink.w_valid = mem_source.w_valid;
        mem_source.w_ready = mem_sink.w_ready;
        mem_sink.w_data = mem_source.w_data;

        // A response can never be older than the oldest tracked request
        mem_source.b_valid = mem_sink.b_valid && wr_not_empty;
        mem_sink.b_ready = mem_source.b_ready && wr_not_empty;
        mem_source.b_id = {wr_saved_id[SRC_ID_WIDTH-1:SINK_ID_WIDTH], mem_sink.b_id};
        mem_source.b_user = wr_saved_user;

        mem_sink.ar_valid = mem_source.ar_valid && rd_not_full;
        mem_source.ar_ready = mem_sink.ar_ready && rd_not_full;
        mem_sink.ar_id = mem_source.ar_id[SINK_ID_WIDTH-1:0];
        mem_sink.ar_addr = mem_source.ar_addr;
        mem_sink.ar_user = mem_source.ar_user[FIM_USER_START +: FIM_USER_WIDTH];

        mem_source.r_valid = mem_sink.r_valid && rd_not_empty;
        mem_sink.r_ready = mem_source.r_ready && rd_not_empty;
        // Upper ID bits come from the tracker, low bits from the sink
        mem_source.r_id = {rd_saved_id[SRC_ID_WIDTH-1:SINK_ID_WIDTH], mem_sink.r_id};
        mem_source.r_user = rd_saved_user;
        mem_source.r_data = mem_sink.r_data;
    end

endmodule

//--- verilog/axi_mem_model.sv
/*
 * Native in-order memory
 * 64-word array with a low-byte write flag
 * Read and write response queues
 */
`timescale 1ns/100ps

module axi_mem_model
    import axi_mem_geom_pkg::*, mem_user_pkg::*;
(
    axi_mem_if.to_source mem
);

    logic clk;
    logic rst_n;

    assign clk = mem.clk;
    assign rst_n = mem.rst_n;

    t_data mem_array [2**ADDR_WIDTH];

    logic wr_accept;
    logic rd_accept;
    logic wr_not_full;
    logic wr_not_empty;
    t_sink_id wr_resp_id;
    logic rd_not_full;
    logic rd_not_empty;
    t_sink_id rd_resp_id;
    t_data rd_resp_data;

    // A write needs address and data together and room for its response
    assign wr_accept = mem.aw_valid && mem.w_valid && wr_not_full;
    assign rd_accept = mem.ar_valid && mem.ar_ready;

    assign mem.aw_ready = wr_accept;
    assign mem.w_ready = wr_accept;
    // Read ready only answers a pending request with room for its response
    assign mem.ar_ready = mem.ar_valid && rd_not_full;

    // Write responses carry only the ID
    mem_track_fifo #(
        .N_DATA_BITS(SINK_ID_WIDTH),
        .N_ENTRIES(RESP_QUEUE_ENTRIES)
    ) wr_queue (
        .clk,
        .rst_n,
        .enq_en(wr_accept),
        .enq_data(mem.aw_id),
        .not_full(wr_not_full),
        .deq_en(mem.b_valid && mem.b_ready),
        .first(wr_resp_id),
        .not_empty(wr_not_empty)
    );

    // Read data is captured at acceptance, before a write on the same edge lands
    mem_track_fifo #(
        .N_DATA_BITS(SINK_ID_WIDTH + DATA_WIDTH),
        .N_ENTRIES(RESP_QUEUE_ENTRIES)
    ) rd_queue (
        .clk,
        .rst_n,
        .enq_en(rd_accept),
        .enq_data({mem.ar_id, mem_array[mem.ar_addr]}),
        .not_full(rd_not_full),
        .deq_en(mem.r_valid && mem.r_ready),
        .first({rd_resp_id, rd_resp_data}),
        .not_empty(rd_not_empty)
    );

    // Responses appear the cycle after acceptance, once the queue holds them
    assign mem.b_valid = wr_not_empty;
    assign mem.b_id = wr_resp_id;
    assign mem.b_user = '0;

    assign mem.r_valid = rd_not_empty;
    assign mem.r_id = rd_resp_id;
    assign mem.r_data = rd_resp_data;
    assign mem.r_user = '0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 2**ADDR_WIDTH; i++)
            begin
                mem_array[i] <= '0;
            end
        end
        else if (wr_accept)
        begin
            // Low-byte writes keep the upper byte of the stored word
            if (mem.aw_user[FIM_FLAG_LOW_BYTE])
            begin
                mem_array[mem.aw_addr][7:0] <= mem.w_data[7:0];
            end
            else
            begin
                mem_array[mem.aw_addr] <= mem.w_data;
            end
        end
    end

endmodule

//--- verilog/axi_mem_top.sv
/*
 * Memory channel adapter top level
 * Plain channel ports, shim and native memory
 */
`timescale 1ns/100ps

module axi_mem_top
    import axi_mem_geom_pkg::*, mem_user_pkg::*;
(
    input logic clk,
    input logic rst_n,

    input logic aw_valid,
    output logic aw_ready,
    input t_src_id aw_id,
    input t_addr aw_addr,
    input t_user aw_user,

    input logic w_valid,
    output logic w_ready,
    input t_data w_data,

    output logic b_valid,
    input logic b_ready,
    output t_src_id b_id,
    output t_user b_user,

    input logic ar_valid,
    output logic ar_ready,
    input t_src_id ar_id,
    input t_addr ar_addr,
    input t_user ar_user,

    output logic r_valid,
    input logic r_ready,
    output t_src_id r_id,
    output t_data r_data,
    output t_user r_user
);

    // Accelerator side carries full IDs and the whole user field
    axi_mem_if #(.ID_WIDTH(SRC_ID_WIDTH), .U_WIDTH(USER_WIDTH)) src_if (.clk, .rst_n);
    // Memory side carries short IDs and device flags only
    axi_mem_if #(.ID_WIDTH(SINK_ID_WIDTH), .U_WIDTH(FIM_USER_WIDTH)) sink_if (.clk, .rst_n);

    // Requests and response readies enter the source channel
    assign src_if.aw_valid = aw_valid;
    assign src_if.aw_id = aw_id;
    assign src_if.aw_addr = aw_addr;
    assign src_if.aw_user = aw_user;
    assign src_if.w_valid = w_valid;
    assign src_if.w_data = w_data;
    assign src_if.b_ready = b_ready;
    assign src_if.ar_valid = ar_valid;
    assign src_if.ar_id = ar_id;
    assign src_if.ar_addr = ar_addr;
    assign src_if.ar_user = ar_user;
    assign src_if.r_ready = r_ready;

    // Request readies and responses leave it
    assign aw_ready = src_if.aw_ready;
    assign w_ready = src_if.w_ready;
    assign b_valid = src_if.b_valid;
    assign b_id = src_if.b_id;
    assign b_user = src_if.b_user;
    assign ar_ready = src_if.ar_ready;
    assign r_valid = src_if.r_valid;
    assign r_id = src_if.r_id;
    assign r_data = src_if.r_data;
    assign r_user = src_if.r_user;

    axi_mem_user_ext u_user_ext (
        .mem_sink(sink_if.to_sink),
        .mem_source(src_if.to_source)
    );

    axi_mem_model u_mem (
        .mem(sink_if.to_source)
    );

endmodule

//--- sim/tb_axi_mem_top.sv
/*
 * Random-stimulus testbench for the memory channel adapter
 * Reference model of the 64-word memory and expected response queues
 * Tests for reset, round trip, ID and user restore, low byte, back-pressure
 */
`timescale 1ns/100ps

module tb_axi_mem_top
    import axi_mem_geom_pkg::*, mem_user_pkg::*;
();

    typedef struct packed {
        t_src_id id;
        t_addr addr;
        t_user user;
        t_data data;
    } t_wr_req;

    typedef struct packed {
        t_src_id id;
        t_addr addr;
        t_user user;
    } t_rd_req;

    typedef struct packed {
        t_src_id id;
        t_user user;
        t_data data;
    } t_resp;

    logic clk;
    logic rst_n;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready;
    t_src_id aw_id, b_id, ar_id, r_id;
    t_addr aw_addr, ar_addr;
    t_user aw_user, b_user, ar_user, r_user;
    t_data w_data, r_data;

    // Pending stimulus and the responses the model expects, oldest first
    t_wr_req wr_stim[$];
    t_rd_req rd_stim[$];
    t_resp exp_b[$];
    t_resp exp_r[$];
    t_data model_mem [2**ADDR_WIDTH];

    // A request stays on the bus until it is accepted
    bit wr_pending;
    bit rd_pending;
    bit timed_out;
    int gap_pct;
    int ready_pct;
    int stall_pct;
    int stall_len_max;
    int b_stall;
    int r_stall;
    int req_stall_seen;
    int err_count;
    int check_count;
    int test_err_base;

    axi_mem_top uut (.*);

    always #2 clk = ~clk;

    function automatic bit chance(input int pct);
        return $urandom_range(99) < pct;
    endfunction

    // Random upper bits over a limited set of low bits, so low IDs repeat
    function automatic t_src_id make_id(input int id_span);
        t_src_id id;
        id = t_src_id'($urandom);
        id[SINK_ID_WIDTH-1:0] = t_sink_id'($urandom_range(id_span - 1));
        return id;
    endfunction

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (expected == actual)
        else
        begin
            $display("error %s expected 0x%0h actual 0x%0h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic queue_write(input t_addr addr, input bit low_byte, input int id_span);
        t_wr_req req;
        req.id = make_id(id_span);
        req.addr = addr;
        req.user = t_user'($urandom);
        req.user[FIM_USER_START + FIM_FLAG_LOW_BYTE] = low_byte;
        req.data = t_data'($urandom);
        wr_stim.push_back(req);
    endtask

    task automatic queue_read(input t_addr addr, input int id_span);
        t_rd_req req;
        req.id = make_id(id_span);
        req.addr = addr;
        req.user = t_user'($urandom);
        rd_stim.push_back(req);
    endtask

    task automatic set_traffic(input int gap, input int ready, input int stall, input int len);
        gap_pct = gap;
        ready_pct = ready;
        stall_pct = stall;
        stall_len_max = len;
    endtask

    // Long low stretches of a response ready come from a stall counter
    task automatic pick_ready(inout int stall, output logic rdy);
        if (stall > 0)
        begin
            stall--;
            rdy = 1'b0;
        end
        else if (chance(stall_pct))
        begin
            stall = $urandom_range(stall_len_max);
            rdy = 1'b0;
        end
        else
        begin
            rdy = chance(ready_pct);
        end
    endtask

    // One clock cycle: observe at the falling edge, drive at the rising edge
    task automatic step();
        t_resp resp;
        t_wr_req wr_req;
        t_rd_req rd_req;
        logic rdy;
        @(negedge clk);
        // Responses are checked before this cycle's requests enter the model
        if (b_valid && b_ready)
        begin
            check_count++;
            assert (exp_b.size() != 0)
            else
            begin
                $display("write response arrived with no write outstanding");
                err_count++;
            end
            if (exp_b.size() != 0)
            begin
                resp = exp_b.pop_front();
                check_field("b_id", resp.id, b_id);
                check_field("b_user", resp.user, b_user);
            end
        end
        if (r_valid && r_ready)
        begin
            check_count++;
            assert (exp_r.size() != 0)
            else
            begin
                $display("read response arrived with no read outstanding");
                err_count++;
            end
            if (exp_r.size() != 0)
            begin
                resp = exp_r.pop_front();
                check_field("r_id", resp.id, r_id);
                check_field("r_user", resp.user, r_user);
                check_field("r_data", resp.data, r_data);
            end
        end
        check_count++;
        assert ((aw_valid && aw_ready) == (w_valid && w_ready))
        else
        begin
            $display("write address and write data were accepted on different edges");
            err_count++;
        end
        if ((aw_valid && !aw_ready) || (ar_valid && !ar_ready))
        begin
            req_stall_seen++;
        end
        // A read sees the array before a write accepted on the same edge
        if (ar_valid && ar_ready)
        begin
            resp.id = ar_id;
            resp.user = ar_user;
            resp.data = model_mem[ar_addr];
            exp_r.push_back(resp);
            rd_pending = 1'b0;
        end
        if (aw_valid && aw_ready)
        begin
            resp.id = aw_id;
            resp.user = aw_user;
            resp.data = '0;
            exp_b.push_back(resp);
            if (aw_user[FIM_USER_START + FIM_FLAG_LOW_BYTE])
            begin
                model_mem[aw_addr][7:0] = w_data[7:0];
            end
            else
            begin
                model_mem[aw_addr] = w_data;
            end
            wr_pending = 1'b0;
        end
        @(posedge clk);
        if (!wr_pending)
        begin
            if (wr_stim.size() != 0 && !chance(gap_pct))
            begin
                wr_req = wr_stim.pop_front();
                aw_id <= wr_req.id;
                aw_addr <= wr_req.addr;
                aw_user <= wr_req.user;
                w_data <= wr_req.data;
                wr_pending = 1'b1;
            end
            aw_valid <= wr_pending;
            w_valid <= wr_pending;
        end
        if (!rd_pending)
        begin
            if (rd_stim.size() != 0 && !chance(gap_pct))
            begin
                rd_req = rd_stim.pop_front();
                ar_id <= rd_req.id;
                ar_addr <= rd_req.addr;
                ar_user <= rd_req.user;
                rd_pending = 1'b1;
            end
            ar_valid <= rd_pending;
        end
        pick_ready(b_stall, rdy);
        b_ready <= rdy;
        pick_ready(r_stall, rdy);
        r_ready <= rdy;
    endtask

    // Run until all stimulus is accepted and every expected response is seen
    task automatic run_traffic(input int limit);
        int cycles;
        cycles = 0;
        while (!timed_out && (wr_stim.size() != 0 || rd_stim.size() != 0 || wr_pending
               || rd_pending || exp_b.size() != 0 || exp_r.size() != 0))
        begin
            step();
            cycles++;
            if (cycles >= limit)
            begin
                timed_out = 1'b1;
                if (exp_b.size() != 0)
                begin
                    $display("timeout: write response for id 0x%0h never came", exp_b[0].id);
                end
                else if (exp_r.size() != 0)
                begin
                    $display("timeout: read response for id 0x%0h never came", exp_r[0].id);
                end
                else
                begin
                    $display("timeout: a request was never accepted");
                end
            end
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s done, %0d errors", name, err_count - test_err_base);
        test_err_base = err_count;
    endtask

    task automatic check_idle();
        check_field("aw_ready", 0, aw_ready);
        check_field("w_ready", 0, w_ready);
        check_field("ar_ready", 0, ar_ready);
        check_field("b_valid", 0, b_valid);
        check_field("r_valid", 0, r_valid);
    endtask

    initial
    begin
        t_addr addrs [16];
        void'($urandom(3289));
        clk = 1'b0;
        rst_n = 1'b0;
        {aw_valid, w_valid, b_ready, ar_valid, r_ready} = '0;
        {aw_id, aw_addr, aw_user, w_data, ar_id, ar_addr, ar_user} = '0;
        for (int i = 0; i < 2**ADDR_WIDTH; i++)
        begin
            model_mem[i] = '0;
        end
        // Every request ready and response valid stays low while reset is held
        repeat (4)
        begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle();
        @(posedge clk);

        // First reads return the cleared array
        set_traffic(0, 100, 0, 0);
        for (int i = 0; i < 8; i++)
        begin
            queue_read(t_addr'($urandom), 16);
        end
        run_traffic(200);
        finish_test("reset state");

        for (int i = 0; i < 16; i++)
        begin
            addrs[i] = t_addr'($urandom);
            queue_write(addrs[i], 1'b0, 16);
        end
        run_traffic(300);
        for (int i = 0; i < 16; i++)
        begin
            queue_read(addrs[i], 16);
        end
        run_traffic(300);
        finish_test("data round trip");

        // Only two low ID values so the upper bits must come from the tracker
        set_traffic(10, 70, 0, 0);
        for (int i = 0; i < 16; i++)
        begin
            queue_write(t_addr'($urandom_range(15)), 1'b0, 2);
            queue_read(t_addr'($urandom_range(15)), 2);
        end
        run_traffic(600);
        finish_test("id and user restore");

        set_traffic(0, 100, 0, 0);
        for (int i = 0; i < 8; i++)
        begin
            queue_write(addrs[i], 1'b0, 16);
        end
        run_traffic(300);
        for (int i = 0; i < 8; i++)
        begin
            queue_write(addrs[i], 1'b1, 16);
        end
        run_traffic(300);
        for (int i = 0; i < 8; i++)
        begin
            queue_read(addrs[i], 16);
        end
        run_traffic(300);
        finish_test("low byte flag");

        // Held-back responses fill the queues and must stall requests
        set_traffic(0, 50, 10, 30);
        req_stall_seen = 0;
        for (int i = 0; i < 40; i++)
        begin
            queue_write(t_addr'($urandom_range(15)), chance(25), 16);
            queue_read(t_addr'($urandom_range(15)), 16);
        end
        run_traffic(4000);
        check_count++;
        assert (req_stall_seen != 0)
        else
        begin
            $display("request readies never dropped while responses were held back");
            err_count++;
        end
        finish_test("back-pressure");

        set_traffic(30, 80, 3, 6);
        for (int i = 0; i < 60; i++)
        begin
            queue_write(t_addr'($urandom_range(15)), chance(25), 16);
            queue_read(t_addr'($urandom_range(15)), 16);
        end
        run_traffic(3000);
        finish_test("mixed traffic");

        $display("checks %0d, errors %0d, timeout %0d", check_count, err_count, timed_out);
        if (err_count == 0 && !timed_out)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- axi_mem_top.f
verilog/axi_mem_geom_pkg.sv
verilog/mem_user_pkg.sv
verilog/axi_mem_if.sv
verilog/mem_track_fifo.sv
verilog/axi_mem_user_ext.sv
verilog/axi_mem_model.sv
verilog/axi_mem_top.sv
sim/tb_axi_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_mem_top \
    -f axi_mem_top.f \
    --Mdir obj_dir -o tb_axi_mem_top

./obj_dir/tb_axi_mem_top | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
